// ==== fpAdder.f ====
source/fpAddPkg.sv
source/fpAddControl.sv
source/fpAlign.sv
source/fpMantissaAdd.sv
source/fpNormalize.sv
source/fpResultQueue.sv
source/fpAdder.sv
sim/fpAdderClock.sv
sim/fpAdderTb.sv

// ==== sim/fpAdderClock.sv ====
// Testbench clock and reset
`default_nettype none
`timescale 1ns/1ps

module fpAdderClock
(
    output logic clock,
    output logic reset
);
    localparam int HalfPeriod = 50;  // 100 ns clock
    localparam int ResetCycles = 8;

    initial
    begin
        clock = 1'b0;
        forever #HalfPeriod clock = ~clock;
    end

    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clock);
        reset <= 1'b0;  // Released on a rising edge like any other input
    end

endmodule

`default_nettype wire

// ==== sim/fpAdderTb.sv ====
// Floating-point adder testbench
`default_nettype none
`timescale 1ns/1ps

module fpAdderTb;
    import fpAddPkg::*;

    localparam int VectorCount = 18;
    localparam int ClockPeriod = 100;
    localparam int ResetCycles = 8;
    localparam int CyclesPerVector = 40;  // Watchdog budget
    localparam int PauseAfter = 8;  // Results before the receiver goes quiet
    localparam int PauseCycles = 60;
    localparam int RandomSeed = 32'h8b30;

    logic  clock;
    logic  reset;
    logic  opValid;
    fpWord opA;
    fpWord opB;
    logic  resultCredit;
    logic  opCredit;
    logic  resultValid;
    fpWord result;

    logic [95:0] vectorTable [VectorCount];  // Operand A, operand B, expected sum
    int          sentCount = 0;
    int          returnedCount = 0;  // opCredit pulses seen
    int          grantedCount = 0;   // resultCredit pulses seen
    int          issuedGrants = 0;
    int          receivedCount = 0;
    logic        pauseDone = 1'b0;
    int unsigned seedState;

    fpAdderClock i_clock (.clock(clock), .reset(reset));

    fpAdder i_dut
    (
        .clock        (clock),
        .reset        (reset),
        .opValid      (opValid),
        .opA          (opA),
        .opB          (opB),
        .resultCredit (resultCredit),
        .opCredit     (opCredit),
        .resultValid  (resultValid),
        .result       (result)
    );

    task automatic loadVectors();
        vectorTable[0]  = {32'h3F800000, 32'h3F800000, 32'h40000000};  // 1 + 1, carry out
        vectorTable[1]  = {32'h3FC00000, 32'h40100000, 32'h40700000};  // 1.5 + 2.25
        vectorTable[2]  = {32'h3F800000, 32'h3F000000, 32'h3FC00000};
        vectorTable[3]  = {32'h3F800000, 32'hBF400000, 32'h3E800000};  // Two leading zeros
        vectorTable[4]  = {32'hC0400000, 32'h3F800000, 32'hC0000000};  // Sign of larger
        vectorTable[5]  = {32'h40490FDB, 32'hC0490FDB, 32'h00000000};  // Exact cancellation
        vectorTable[6]  = {32'h3F800000, 32'h33800000, 32'h3F800000};  // Tie, stays even
        vectorTable[7]  = {32'h3F800001, 32'h33800000, 32'h3F800002};  // Tie, rounds up
        vectorTable[8]  = {32'h3FFFFFFF, 32'h33800000, 32'h40000000};  // Rounding carry
        vectorTable[9]  = {32'h7FC00001, 32'h7FC00002, 32'h7FC00001};  // A NaN wins
        vectorTable[10] = {32'h3F800000, 32'h7FC00002, 32'h7FC00002};
        vectorTable[11] = {32'h7F800000, 32'h3F800000, 32'h7F800000};
        vectorTable[12] = {32'h3F800000, 32'hFF800000, 32'hFF800000};
        vectorTable[13] = {32'hFF800000, 32'hFF800000, 32'hFF800000};
        vectorTable[14] = {32'h7F800000, 32'hFF800000, 32'h7FFFFFFF};  // Inf minus inf
        vectorTable[15] = {32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000};  // Overflow
        vectorTable[16] = {32'h00000001, 32'h00000002, 32'h00000003};  // Subnormals
        vectorTable[17] = {32'h00400000, 32'h00400000, 32'h00800000};  // Reaches normal
    endtask

    task automatic abortRun();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        $display("CHECK FAILED %s %h expected %h", name, actual, expected);
        abortRun();
    endtask

    task automatic reportProblem(input string reason);
        $display("%s", reason);
        abortRun();
    endtask

    // Operand driver, spends one upstream credit per send
    initial
    begin
        opValid = 1'b0;
        opA = '0;
        opB = '0;
        resultCredit = 1'b0;
        seedState = RandomSeed;
        seedState = $urandom(seedState);
        loadVectors();
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        repeat (4) @(posedge clock);  // Quiet window after reset
        for (int i = 0; i < VectorCount; i++)
        begin
            @(posedge clock);
            while ((sentCount - returnedCount >= QueueDepth) || ($urandom % 4 == 0))
            begin
                opValid <= 1'b0;
                @(posedge clock);
            end
            opValid <= 1'b1;
            opA <= vectorTable[i][95:64];
            opB <= vectorTable[i][63:32];
            sentCount++;
        end
        @(posedge clock);
        opValid <= 1'b0;
        wait (receivedCount == VectorCount);
        repeat (20) @(posedge clock);  // Stray results would show here
        $display("No errors");
        $finish;
    end

    // Receiver, random grants with one long pause
    initial
    begin
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        while (receivedCount < VectorCount)
        begin
            @(posedge clock);
            if ((receivedCount == PauseAfter) && !pauseDone)
            begin
                pauseDone = 1'b1;
                resultCredit <= 1'b0;
                repeat (PauseCycles) @(posedge clock);
            end
            if ((issuedGrants - receivedCount < QueueDepth) && ($urandom % 3 != 0))
            begin
                resultCredit <= 1'b1;
                issuedGrants++;
            end
            else
                resultCredit <= 1'b0;
        end
        @(posedge clock);
        resultCredit <= 1'b0;
    end

    // Outputs are settled mid-cycle
    always @(negedge clock)
    begin
        if (reset === 1'b0)
        begin
            if (sentCount == 0)
                assert (!resultValid && !opCredit)
                else reportProblem("Output activity after reset before any operand was sent");
            assert (opCredit === resultValid)
            else reportMismatch("opCredit", 32'(opCredit), 32'(resultValid));
            if (resultValid)
            begin
                assert (grantedCount > receivedCount)
                else reportProblem("A result was sent without a granted credit");
                assert (receivedCount < VectorCount)
                else reportProblem("More results arrived than operands were sent");
                assert (result === vectorTable[receivedCount][31:0])
                else reportMismatch("result", result, vectorTable[receivedCount][31:0]);
                receivedCount++;
            end
            if (resultCredit)
                grantedCount++;
            if (opCredit)
            begin
                assert (returnedCount < sentCount)
                else reportProblem("A credit came back for an operand that was never sent");
                returnedCount++;
            end
        end
    end

    initial
    begin
        #((VectorCount * CyclesPerVector + ResetCycles) * ClockPeriod);
        $display("Timeout, results stopped arriving after %0d of %0d", receivedCount,
                 VectorCount);
        abortRun();
    end

endmodule

`default_nettype wire

// ==== source/fpAddControl.sv ====
// Adder flow control
`default_nettype none
`timescale 1ns/1ps

module fpAddControl
(
    input  logic clock,
    input  logic reset,
    input  logic opValid,
    input  logic resultCredit,
    input  logic queueEmpty,
    output logic queuePush,
    output logic queuePop,
    output logic opCredit,
    output logic resultValid
);
    import fpAddPkg::*;

    logic [StageCount-1:0]  validPipe;   // One bit per datapath stage
    logic [CreditWidth-1:0] outCredits;  // Credits granted by the receiver

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            validPipe <= '0;
            outCredits <= '0;
        end
        else
        begin
            validPipe <= {validPipe[StageCount-2:0], opValid};
            // Receiver grants and our own sends can land in the same cycle
            outCredits <= outCredits + CreditWidth'(resultCredit)
                        - CreditWidth'(queuePop);
        end
    end

    // Last stage register holds a result, so it enters the queue next edge
    assign queuePush = validPipe[StageCount-1];

    // Send only against a held credit
    assign queuePop = !queueEmpty && (outCredits != '0);

    assign resultValid = queuePop;
    assign opCredit = queuePop;  // Freed queue slot goes back upstream

endmodule

`default_nettype wire

// ==== source/fpAddPkg.sv ====
// Floating-point adder shared definitions
`default_nettype none

package fpAddPkg;

    // IEEE 754 binary32 field widths
    localparam int ExpWidth = 8;
    localparam int MantWidth = 23;
    localparam logic [ExpWidth-1:0] ExpMax = 8'hFF;  // Infinity and NaN exponent

    // Pipeline and flow control sizing
    localparam int StageCount = 3;
    localparam int QueueDepth = 4;
    localparam int PtrWidth = $clog2(QueueDepth);
    localparam int CreditWidth = 3;  // Counts 0 to QueueDepth

    typedef struct packed {
        logic                 sign;
        logic [ExpWidth-1:0]  exponent;
        logic [MantWidth-1:0] mantissa;
    } fpWord;

    // Result of infinity minus infinity
    localparam fpWord DefaultNan = '{1'b0, ExpMax, {MantWidth{1'b1}}};

    // Alignment to mantissa addition
    typedef struct packed {
        logic [MantWidth:0]  mantLarge;  // Hidden bit included
        logic [MantWidth:0]  mantSmall;  // Already shifted right
        logic                signLarge;
        logic                signSmall;
        logic [ExpWidth-1:0] exponent;
        logic                guardBit;
        logic                roundBit;
        logic                stickyBit;
        fpWord               a;
        fpWord               b;
    } alignedOp;

    // Mantissa addition to normalization
    typedef struct packed {
        logic [MantWidth:0]  alignedResult;
        logic                carryOut;
        logic                sign;
        logic [ExpWidth-1:0] exponentOut;
        logic                guardBit;
        logic                roundBit;
        logic                stickyBit;
        fpWord               a;
        fpWord               b;
    } sumOp;

endpackage

`default_nettype wire

// ==== source/fpAdder.sv ====
// Pipelined floating-point adder
`default_nettype none
`timescale 1ns/1ps

module fpAdder
(
    input  logic            clock,
    input  logic            reset,
    input  logic            opValid,
    input  fpAddPkg::fpWord opA,
    input  fpAddPkg::fpWord opB,
    input  logic            resultCredit,
    output logic            opCredit,
    output logic            resultValid,
    output fpAddPkg::fpWord result
);
    import fpAddPkg::*;

    alignedOp aligned;
    sumOp     sum;
    fpWord    normalized;
    logic     queuePush;
    logic     queuePop;
    logic     queueEmpty;

    fpAddControl i_control
    (
        .clock        (clock),
        .reset        (reset),
        .opValid      (opValid),
        .resultCredit (resultCredit),
        .queueEmpty   (queueEmpty),
        .queuePush    (queuePush),
        .queuePop     (queuePop),
        .opCredit     (opCredit),
        .resultValid  (resultValid)
    );

    fpAlign i_align (.clock(clock), .opA(opA), .opB(opB), .aligned(aligned));

    fpMantissaAdd i_mantissaAdd (.clock(clock), .aligned(aligned), .sum(sum));

    fpNormalize i_normalize (.clock(clock), .sum(sum), .normalized(normalized));

    fpResultQueue i_resultQueue
    (
        .clock     (clock),
        .reset     (reset),
        .push      (queuePush),
        .pop       (queuePop),
        .writeData (normalized),
        .readData  (result),
        .empty     (queueEmpty)
    );

endmodule

`default_nettype wire

// ==== source/fpAlign.sv ====
// Operand alignment stage
`default_nettype none
`timescale 1ns/1ps

module fpAlign
(
    input  logic               clock,
    input  fpAddPkg::fpWord    opA,
    input  fpAddPkg::fpWord    opB,
    output fpAddPkg::alignedOp aligned
);
    import fpAddPkg::*;

    logic                    aFirst;
    fpWord                   opLarge;
    fpWord                   opSmall;
    logic [ExpWidth-1:0]     expLarge;
    logic [ExpWidth-1:0]     expSmall;
    logic [ExpWidth-1:0]     expDiff;
    logic [MantWidth:0]      mantLarge;
    logic [MantWidth:0]      mantSmall;
    logic [4:0]              shiftAmount;
    logic [2*MantWidth+3:0]  shiftWide;  // Mantissa, guard, round, sticky field
    alignedOp                alignNext;

    always_comb
    begin
        // Order by exponent, then by mantissa
        aFirst = {opA.exponent, opA.mantissa} >= {opB.exponent, opB.mantissa};
        opLarge = aFirst ? opA : opB;
        opSmall = aFirst ? opB : opA;

        // Subnormals sit at an effective exponent of 1
        expLarge = (opLarge.exponent == '0) ? 8'd1 : opLarge.exponent;
        expSmall = (opSmall.exponent == '0) ? 8'd1 : opSmall.exponent;
        expDiff = expLarge - expSmall;

        mantLarge = {opLarge.exponent != '0, opLarge.mantissa};  // Hidden bit
        mantSmall = {opSmall.exponent != '0, opSmall.mantissa};

        // Beyond 26 everything is sticky anyway
        shiftAmount = (expDiff > 8'd26) ? 5'd26 : expDiff[4:0];
        shiftWide = {mantSmall, 26'b0} >> shiftAmount;

        alignNext.mantLarge = mantLarge;
        alignNext.mantSmall = shiftWide[2*MantWidth+3:26];
        alignNext.signLarge = opLarge.sign;
        alignNext.signSmall = opSmall.sign;
        alignNext.exponent = opLarge.exponent;
        alignNext.guardBit = shiftWide[25];
        alignNext.roundBit = shiftWide[24];
        alignNext.stickyBit = |shiftWide[23:0];  // Anything lost below round
        alignNext.a = opA;
        alignNext.b = opB;
    end

    always_ff @(posedge clock)
    begin
        aligned <= alignNext;
    end

endmodule

`default_nettype wire

// ==== source/fpMantissaAdd.sv ====
// Mantissa addition stage
`default_nettype none
`timescale 1ns/1ps

module fpMantissaAdd
(
    input  logic               clock,
    input  fpAddPkg::alignedOp aligned,
    output fpAddPkg::sumOp     sum
);
    import fpAddPkg::*;

    logic [MantWidth+4:0] extLarge;   // Carry, mantissa, guard, round, sticky
    logic [MantWidth+4:0] extSmall;
    logic [MantWidth+4:0] extResult;
    logic                 effSub;
    logic                 cancel;
    logic                 special;
    sumOp                 sumNext;

    always_comb
    begin
        effSub = aligned.signLarge != aligned.signSmall;
        extLarge = {1'b0, aligned.mantLarge, 3'b000};
        extSmall = {1'b0, aligned.mantSmall, aligned.guardBit, aligned.roundBit,
                    aligned.stickyBit};

        // Larger magnitude comes first, so the difference never borrows
        extResult = effSub ? extLarge - extSmall : extLarge + extSmall;

        cancel = effSub && (extResult == '0);
        special = (aligned.a.exponent == ExpMax) || (aligned.b.exponent == ExpMax);

        sumNext.alignedResult = extResult[MantWidth+3:3];
        sumNext.carryOut = extResult[MantWidth+4];
        sumNext.guardBit = extResult[2];
        sumNext.roundBit = extResult[1];
        sumNext.stickyBit = extResult[0];
        sumNext.sign = cancel ? 1'b0 : aligned.signLarge;  // Exact zero is positive
        sumNext.exponentOut = cancel ? '0 : aligned.exponent;
        if (special)
            sumNext.exponentOut = ExpMax;  // Routes to the NaN and infinity rules
        sumNext.a = aligned.a;
        sumNext.b = aligned.b;
    end

    always_ff @(posedge clock)
    begin
        sum <= sumNext;
    end

endmodule

`default_nettype wire

// ==== source/fpNormalize.sv ====
// Result normalization and rounding
`default_nettype none
`timescale 1ns/1ps

module fpNormalize
(
    input  logic            clock,
    input  fpAddPkg::sumOp  sum,
    output fpAddPkg::fpWord normalized
);
    import fpAddPkg::*;

    logic [4:0]           shiftAmount;
    logic [MantWidth+2:0] shiftedMantissa;  // Result with guard and round
    logic [MantWidth:0]   mantWork;
    logic                 guardWork;
    logic                 roundWork;
    logic                 stickyWork;
    logic                 roundUp;
    logic                 roundCarry;
    logic [MantWidth:0]   mantRounded;
    logic [ExpWidth:0]    expWork;
    logic [ExpWidth:0]    expRounded;
    logic                 underflow;
    logic                 nanA;
    logic                 nanB;
    logic                 infA;
    logic                 infB;
    fpWord                normNext;

    // Leading zeros of the 24-bit mantissa
    function automatic logic [4:0] countZeros(input logic [MantWidth:0] value);
        logic [4:0] zeros;
        zeros = 5'd24;
        for (int i = 0; i <= MantWidth; i++)
            if (value[i])
                zeros = 5'(MantWidth - i);  // Highest set bit wins
        return zeros;
    endfunction

    always_comb
    begin
        nanA = (sum.a.exponent == ExpMax) && (sum.a.mantissa != '0);
        nanB = (sum.b.exponent == ExpMax) && (sum.b.mantissa != '0);
        infA = (sum.a.exponent == ExpMax) && (sum.a.mantissa == '0);
        infB = (sum.b.exponent == ExpMax) && (sum.b.mantissa == '0);

        shiftAmount = countZeros(sum.alignedResult);
        shiftedMantissa = {sum.alignedResult, sum.guardBit, sum.roundBit} << shiftAmount;
        underflow = !sum.carryOut && (shiftAmount >= sum.exponentOut);

        if (sum.carryOut)
        begin
            // Shift right by one, carry becomes the hidden bit
            mantWork = {1'b1, sum.alignedResult[MantWidth:1]};
            guardWork = sum.alignedResult[0];
            roundWork = sum.guardBit;
            stickyWork = sum.roundBit | sum.stickyBit;
            expWork = {1'b0, sum.exponentOut} + 1'b1;
        end
        else
        begin
            mantWork = shiftedMantissa[MantWidth+2:2];
            guardWork = shiftedMantissa[1];
            roundWork = shiftedMantissa[0];
            stickyWork = sum.stickyBit;
            expWork = {1'b0, sum.exponentOut} - shiftAmount;  // Wrap caught by underflow
        end

        // Nearest, ties to even
        roundUp = guardWork & (roundWork | stickyWork | mantWork[0]);
        {roundCarry, mantRounded} = {1'b0, mantWork} + roundUp;
        expRounded = expWork + roundCarry;  // All-ones mantissa rolls over to zero

        if (sum.exponentOut == '0)
        begin
            // Subnormal sum, bit 23 set means it reached the smallest normal
            normNext.sign = sum.sign;
            normNext.exponent = {{(ExpWidth-1){1'b0}}, sum.alignedResult[MantWidth]};
            normNext.mantissa = sum.alignedResult[MantWidth-1:0];
        end
        else if (sum.exponentOut == ExpMax)
        begin
            if (nanA)
                normNext = sum.a;
            else if (nanB)
                normNext = sum.b;
            else if (infA && infB && (sum.a.sign != sum.b.sign))
                normNext = DefaultNan;
            else if (infA)
                normNext = sum.a;
            else
                normNext = sum.b;
        end
        else if (underflow)
            normNext = '{sum.sign, '0, '0};  // Flush to signed zero
        else if (expRounded >= {1'b0, ExpMax})
            normNext = '{sum.sign, ExpMax, '0};  // Overflow to infinity
        else
        begin
            normNext.sign = sum.sign;
            normNext.exponent = expRounded[ExpWidth-1:0];
            normNext.mantissa = mantRounded[MantWidth-1:0];
        end
    end

    always_ff @(posedge clock)
    begin
        normalized <= normNext;
    end

endmodule

`default_nettype wire

// ==== source/fpResultQueue.sv ====
// Result FIFO
`default_nettype none
`timescale 1ns/1ps

module fpResultQueue
(
    input  logic            clock,
    input  logic            reset,
    input  logic            push,
    input  logic            pop,
    input  fpAddPkg::fpWord writeData,
    output fpAddPkg::fpWord readData,
    output logic            empty
);
    import fpAddPkg::*;

    fpWord                  entries [QueueDepth];
    logic [PtrWidth-1:0]    readPtr;
    logic [PtrWidth-1:0]    writePtr;
    logic [CreditWidth-1:0] count;  // Occupied entries

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                writePtr <= writePtr + 1'b1;  // Depth is a power of two
            if (pop)
                readPtr <= readPtr + 1'b1;
            count <= count + CreditWidth'(push) - CreditWidth'(pop);
        end
    end

    always_ff @(posedge clock)
    begin
        if (push)
            entries[writePtr] <= writeData;
    end

    assign readData = entries[readPtr];  // Oldest entry
    assign empty = (count == '0);

endmodule

`default_nettype wire
